/* design/rt_pd_pkg.sv */
`default_nettype none

package rt_pd_pkg;

	// Data widths
	localparam int THREAD_W = 5;
	localparam int SCALAR_W = 32;
	localparam int LANE_W = 32;
	localparam int NUM_LANES = 4;
	localparam int VECTOR_W = LANE_W * NUM_LANES;

	// Register file depths
	localparam int NUM_SCALAR_REGS = 32;
	localparam int NUM_VECTOR_REGS = 16;

	typedef logic [THREAD_W-1:0] thread_id_t;
	typedef logic [SCALAR_W-1:0] scalar_t;
	typedef logic [VECTOR_W-1:0] vector_t;
	typedef logic [$clog2(NUM_SCALAR_REGS)-1:0] sreg_addr_t;
	typedef logic [$clog2(NUM_VECTOR_REGS)-1:0] vreg_addr_t;

	// Scalar register map
	localparam sreg_addr_t SREG_PC = 5'd1;
	localparam sreg_addr_t SREG_SP = 5'd2;
	localparam sreg_addr_t SREG_PIXEL_ID = 5'd3;
	localparam sreg_addr_t SREG_THREAD_ID = 5'd4;
	// Flag sits in bit 0
	localparam sreg_addr_t SREG_DE_Q = 5'd5;

	// Vector register map
	localparam vreg_addr_t VREG_SHADER = 4'd1;
	localparam vreg_addr_t VREG_NORMAL = 4'd2;
	localparam vreg_addr_t VREG_ORIGIN = 4'd3;
	localparam vreg_addr_t VREG_DIRECTION = 4'd4;

	// Cycles spent writing a job into the banks
	localparam int LOAD_CYCLES = 4;

endpackage

`default_nettype wire

/* design/rt_job_latch.sv */
`default_nettype none
`timescale 1ns/10ps

module rt_job_latch (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   job_assign,
	input  rt_pd_pkg::thread_id_t  thread_id_in,
	input  rt_pd_pkg::scalar_t     pixel_id_in,
	input  rt_pd_pkg::scalar_t     program_counter_in,
	input  rt_pd_pkg::scalar_t     stack_ptr_in,
	input  rt_pd_pkg::vector_t     shader_info,
	input  rt_pd_pkg::vector_t     normal,
	input  logic                   done,
	output logic                   job_valid,
	output logic                   busy,
	output rt_pd_pkg::thread_id_t  thread_id,
	output rt_pd_pkg::scalar_t     pixel_id,
	output rt_pd_pkg::scalar_t     program_counter,
	output rt_pd_pkg::scalar_t     stack_ptr,
	output rt_pd_pkg::vector_t     shader,
	output rt_pd_pkg::vector_t     job_normal
);

	logic accept;

	// New jobs only land while idle
	assign accept = job_assign && !busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			job_valid <= 1'b0;
		end else begin
			job_valid <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			thread_id <= thread_id_in;
			pixel_id <= pixel_id_in;
			program_counter <= program_counter_in;
			stack_ptr <= stack_ptr_in;
			shader <= shader_info;
			job_normal <= normal;
		end
	end

	// Dispatcher should wait for task done before reassigning
	a_assign_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(job_assign && busy))
		else $warning("job_assign while busy, job ignored");

endmodule

`default_nettype wire

/* design/rt_context_loader.sv */
`default_nettype none
`timescale 1ns/10ps

module rt_context_loader (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   job_valid,
	input  rt_pd_pkg::thread_id_t  thread_id,
	input  rt_pd_pkg::scalar_t     pixel_id,
	input  rt_pd_pkg::scalar_t     program_counter,
	input  rt_pd_pkg::scalar_t     stack_ptr,
	input  rt_pd_pkg::vector_t     shader,
	input  rt_pd_pkg::vector_t     job_normal,
	output logic                   kernel_mode,
	output logic                   s_we,
	output rt_pd_pkg::sreg_addr_t  s_addr,
	output rt_pd_pkg::scalar_t     s_data,
	output logic                   v_we,
	output rt_pd_pkg::vreg_addr_t  v_addr,
	output rt_pd_pkg::vector_t     v_data
);

	localparam int STEP_W = $clog2(rt_pd_pkg::LOAD_CYCLES);

	logic [STEP_W-1:0] step;
	logic last_step;

	assign last_step = (step == STEP_W'(rt_pd_pkg::LOAD_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			kernel_mode <= 1'b0;
			step <= '0;
		end else if (kernel_mode) begin
			step <= step + 1'b1;
			if (last_step) begin
				kernel_mode <= 1'b0;
			end
		end else if (job_valid) begin
			kernel_mode <= 1'b1;
			step <= '0;
		end
	end

	// One scalar write every step, vector writes only in the first two
	assign s_we = kernel_mode;

	always_comb begin
		v_we = 1'b0;
		v_addr = rt_pd_pkg::VREG_SHADER;
		v_data = shader;
		case (step)
			STEP_W'(0): begin
				s_addr = rt_pd_pkg::SREG_PC;
				s_data = program_counter;
				v_we = kernel_mode;
			end
			STEP_W'(1): begin
				s_addr = rt_pd_pkg::SREG_SP;
				s_data = stack_ptr;
				v_we = kernel_mode;
				v_addr = rt_pd_pkg::VREG_NORMAL;
				v_data = job_normal;
			end
			STEP_W'(2): begin
				s_addr = rt_pd_pkg::SREG_PIXEL_ID;
				s_data = pixel_id;
			end
			default: begin
				s_addr = rt_pd_pkg::SREG_THREAD_ID;
				s_data = rt_pd_pkg::scalar_t'(thread_id);
			end
		endcase
	end

	// Latch must hold off new jobs until the load has finished
	a_no_valid_in_kernel: assert property (@(posedge clk) disable iff (!rst_n)
		!(job_valid && kernel_mode));

endmodule

`default_nettype wire

/* design/rt_reg_bank.sv */
`default_nettype none
`timescale 1ns/10ps

module rt_reg_bank #(
	parameter type word_t = rt_pd_pkg::scalar_t,
	parameter int DEPTH = 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     pri_we,
	input  logic [$clog2(DEPTH)-1:0] pri_addr,
	input  word_t                    pri_data,
	input  logic                     core_we,
	input  logic [$clog2(DEPTH)-1:0] core_addr,
	input  word_t                    core_data,
	input  logic [$clog2(DEPTH)-1:0] rd_addr_0,
	input  logic [$clog2(DEPTH)-1:0] rd_addr_1,
	input  logic [$clog2(DEPTH)-1:0] rd_addr_2,
	output word_t                    rd_data_0,
	output word_t                    rd_data_1,
	output word_t                    rd_data_2
);

	word_t regs [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (core_we) begin
				regs[core_addr] <= core_data;
			end
			// Loader write comes last so it wins on the same address
			if (pri_we) begin
				regs[pri_addr] <= pri_data;
			end
		end
	end

	assign rd_data_0 = regs[rd_addr_0];
	assign rd_data_1 = regs[rd_addr_1];
	assign rd_data_2 = regs[rd_addr_2];

	// Non power-of-two depths leave addresses past the end
	a_addr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(!pri_we || int'(pri_addr) < DEPTH) &&
		(!core_we || int'(core_addr) < DEPTH) &&
		int'(rd_addr_0) < DEPTH &&
		int'(rd_addr_1) < DEPTH &&
		int'(rd_addr_2) < DEPTH);

endmodule

`default_nettype wire

/* design/rt_context_saver.sv */
`default_nettype none
`timescale 1ns/10ps

module rt_context_saver (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   kernel_mode,
	input  logic                   context_switch_rt,
	input  logic                   end_program,
	input  rt_pd_pkg::thread_id_t  thread_id,
	input  rt_pd_pkg::scalar_t     s_rd_data_0,
	input  rt_pd_pkg::scalar_t     s_rd_data_1,
	input  rt_pd_pkg::vector_t     v_rd_data_0,
	input  rt_pd_pkg::vector_t     v_rd_data_1,
	output rt_pd_pkg::sreg_addr_t  s_rd_addr_0,
	output rt_pd_pkg::sreg_addr_t  s_rd_addr_1,
	output rt_pd_pkg::vreg_addr_t  v_rd_addr_0,
	output rt_pd_pkg::vreg_addr_t  v_rd_addr_1,
	output logic                   context_switch_pd,
	output logic                   task_done_pd,
	output logic                   done,
	output rt_pd_pkg::thread_id_t  thread_id_out,
	output rt_pd_pkg::scalar_t     program_counter_out,
	output rt_pd_pkg::scalar_t     stack_ptr_out,
	output logic                   de_q,
	output rt_pd_pkg::vector_t     origin,
	output rt_pd_pkg::vector_t     direction
);

	logic do_switch;
	logic do_end;

	// Strobes are dropped while the loader owns the banks
	assign do_switch = context_switch_rt && !kernel_mode;
	assign do_end = end_program && !kernel_mode;

	// Scalar port 0 serves PC on a switch, de_q at end of program
	assign s_rd_addr_0 = end_program ? rt_pd_pkg::SREG_DE_Q : rt_pd_pkg::SREG_PC;
	assign s_rd_addr_1 = rt_pd_pkg::SREG_SP;
	assign v_rd_addr_0 = rt_pd_pkg::VREG_ORIGIN;
	assign v_rd_addr_1 = rt_pd_pkg::VREG_DIRECTION;

	// Frees the latch on the same edge that raises task_done_pd
	assign done = do_end;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			context_switch_pd <= 1'b0;
			task_done_pd <= 1'b0;
		end else begin
			context_switch_pd <= do_switch;
			task_done_pd <= do_end;
		end
	end

	always_ff @(posedge clk) begin
		if (do_switch || do_end) begin
			thread_id_out <= thread_id;
		end
		if (do_switch) begin
			program_counter_out <= s_rd_data_0;
			stack_ptr_out <= s_rd_data_1;
		end
		if (do_end) begin
			de_q <= s_rd_data_0[0];
			origin <= v_rd_data_0;
			direction <= v_rd_data_1;
		end
	end

	// Shared scalar read port cannot serve both at once
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!(context_switch_rt && end_program));

endmodule

`default_nettype wire

/* design/rt_pd_icm_interface.sv */
`default_nettype none
`timescale 1ns/10ps

module rt_pd_icm_interface #(
	parameter int SCALAR_DEPTH = rt_pd_pkg::NUM_SCALAR_REGS,
	parameter int VECTOR_DEPTH = rt_pd_pkg::NUM_VECTOR_REGS
) (
	input  logic                   clk,
	input  logic                   rst_n,
	// Pixel dispatcher
	input  logic                   job_assign,
	input  rt_pd_pkg::thread_id_t  thread_id_in,
	input  rt_pd_pkg::scalar_t     pixel_id_in,
	input  rt_pd_pkg::scalar_t     program_counter_in,
	input  rt_pd_pkg::scalar_t     stack_ptr_in,
	input  rt_pd_pkg::vector_t     shader_info,
	input  rt_pd_pkg::vector_t     normal,
	output logic                   context_switch_pd,
	output logic                   task_done_pd,
	output rt_pd_pkg::thread_id_t  thread_id_out,
	output rt_pd_pkg::scalar_t     program_counter_out,
	output rt_pd_pkg::scalar_t     stack_ptr_out,
	output logic                   de_q,
	output rt_pd_pkg::vector_t     origin,
	output rt_pd_pkg::vector_t     direction,
	// Core side
	output logic                   kernel_mode,
	input  logic                   context_switch_rt,
	input  logic                   end_program,
	input  logic                   core_scalar_we,
	input  rt_pd_pkg::sreg_addr_t  core_scalar_wb_addr,
	input  rt_pd_pkg::scalar_t     core_scalar_wb_data,
	input  logic                   core_vector_we,
	input  rt_pd_pkg::vreg_addr_t  core_vector_wb_addr,
	input  rt_pd_pkg::vector_t     core_vector_wb_data,
	input  rt_pd_pkg::sreg_addr_t  core_scalar_rd_addr,
	output rt_pd_pkg::scalar_t     core_scalar_rd_data,
	input  rt_pd_pkg::vreg_addr_t  core_vector_rd_addr,
	output rt_pd_pkg::vector_t     core_vector_rd_data
);

	logic job_valid;
	logic busy;
	logic done;
	rt_pd_pkg::thread_id_t thread_id;
	rt_pd_pkg::scalar_t pixel_id;
	rt_pd_pkg::scalar_t program_counter;
	rt_pd_pkg::scalar_t stack_ptr;
	rt_pd_pkg::vector_t shader;
	rt_pd_pkg::vector_t job_normal;

	logic s_we;
	rt_pd_pkg::sreg_addr_t s_addr;
	rt_pd_pkg::scalar_t s_data;
	logic v_we;
	rt_pd_pkg::vreg_addr_t v_addr;
	rt_pd_pkg::vector_t v_data;

	rt_pd_pkg::sreg_addr_t s_rd_addr_0;
	rt_pd_pkg::sreg_addr_t s_rd_addr_1;
	rt_pd_pkg::vreg_addr_t v_rd_addr_0;
	rt_pd_pkg::vreg_addr_t v_rd_addr_1;
	rt_pd_pkg::scalar_t s_rd_data_0;
	rt_pd_pkg::scalar_t s_rd_data_1;
	rt_pd_pkg::vector_t v_rd_data_0;
	rt_pd_pkg::vector_t v_rd_data_1;

	rt_job_latch u_job_latch (
		.clk(clk), .rst_n(rst_n), .job_assign(job_assign),
		.thread_id_in(thread_id_in), .pixel_id_in(pixel_id_in),
		.program_counter_in(program_counter_in), .stack_ptr_in(stack_ptr_in),
		.shader_info(shader_info), .normal(normal), .done(done),
		.job_valid(job_valid), .busy(busy), .thread_id(thread_id),
		.pixel_id(pixel_id), .program_counter(program_counter),
		.stack_ptr(stack_ptr), .shader(shader), .job_normal(job_normal)
	);

	rt_context_loader u_loader (
		.clk(clk), .rst_n(rst_n), .job_valid(job_valid),
		.thread_id(thread_id), .pixel_id(pixel_id),
		.program_counter(program_counter), .stack_ptr(stack_ptr),
		.shader(shader), .job_normal(job_normal), .kernel_mode(kernel_mode),
		.s_we(s_we), .s_addr(s_addr), .s_data(s_data),
		.v_we(v_we), .v_addr(v_addr), .v_data(v_data)
	);

	rt_reg_bank #(.word_t(rt_pd_pkg::scalar_t), .DEPTH(SCALAR_DEPTH)) u_scalar_bank (
		.clk(clk), .rst_n(rst_n),
		.pri_we(s_we), .pri_addr(s_addr), .pri_data(s_data),
		.core_we(core_scalar_we), .core_addr(core_scalar_wb_addr),
		.core_data(core_scalar_wb_data),
		.rd_addr_0(s_rd_addr_0), .rd_addr_1(s_rd_addr_1), .rd_addr_2(core_scalar_rd_addr),
		.rd_data_0(s_rd_data_0), .rd_data_1(s_rd_data_1), .rd_data_2(core_scalar_rd_data)
	);

	rt_reg_bank #(.word_t(rt_pd_pkg::vector_t), .DEPTH(VECTOR_DEPTH)) u_vector_bank (
		.clk(clk), .rst_n(rst_n),
		.pri_we(v_we), .pri_addr(v_addr), .pri_data(v_data),
		.core_we(core_vector_we), .core_addr(core_vector_wb_addr),
		.core_data(core_vector_wb_data),
		.rd_addr_0(v_rd_addr_0), .rd_addr_1(v_rd_addr_1), .rd_addr_2(core_vector_rd_addr),
		.rd_data_0(v_rd_data_0), .rd_data_1(v_rd_data_1), .rd_data_2(core_vector_rd_data)
	);

	rt_context_saver u_saver (
		.clk(clk), .rst_n(rst_n), .kernel_mode(kernel_mode),
		.context_switch_rt(context_switch_rt), .end_program(end_program),
		.thread_id(thread_id),
		.s_rd_data_0(s_rd_data_0), .s_rd_data_1(s_rd_data_1),
		.v_rd_data_0(v_rd_data_0), .v_rd_data_1(v_rd_data_1),
		.s_rd_addr_0(s_rd_addr_0), .s_rd_addr_1(s_rd_addr_1),
		.v_rd_addr_0(v_rd_addr_0), .v_rd_addr_1(v_rd_addr_1),
		.context_switch_pd(context_switch_pd), .task_done_pd(task_done_pd),
		.done(done), .thread_id_out(thread_id_out),
		.program_counter_out(program_counter_out), .stack_ptr_out(stack_ptr_out),
		.de_q(de_q), .origin(origin), .direction(direction)
	);

	// Saver only runs once a job has been accepted
	a_end_needs_job: assert property (@(posedge clk) disable iff (!rst_n)
		(end_program && !kernel_mode) |-> busy);

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* verif/tb_rt_pd_icm_interface.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_rt_pd_icm_interface;

	localparam int TIMEOUT = 40;

	logic clk;
	logic rst_n;
	// Dispatcher side
	logic job_assign = 1'b0;
	rt_pd_pkg::thread_id_t thread_id_in = '0;
	rt_pd_pkg::scalar_t pixel_id_in = '0, program_counter_in = '0, stack_ptr_in = '0;
	rt_pd_pkg::vector_t shader_info = '0, normal = '0;
	logic context_switch_pd, task_done_pd, de_q;
	rt_pd_pkg::thread_id_t thread_id_out;
	rt_pd_pkg::scalar_t program_counter_out, stack_ptr_out;
	rt_pd_pkg::vector_t origin, direction;
	// Core side
	logic kernel_mode;
	logic context_switch_rt = 1'b0, end_program = 1'b0;
	logic core_scalar_we = 1'b0, core_vector_we = 1'b0;
	rt_pd_pkg::sreg_addr_t core_scalar_wb_addr = '0, core_scalar_rd_addr = '0;
	rt_pd_pkg::vreg_addr_t core_vector_wb_addr = '0, core_vector_rd_addr = '0;
	rt_pd_pkg::scalar_t core_scalar_wb_data = '0;
	rt_pd_pkg::vector_t core_vector_wb_data = '0;
	rt_pd_pkg::scalar_t core_scalar_rd_data;
	rt_pd_pkg::vector_t core_vector_rd_data;

	// Job most recently accepted by the DUT
	rt_pd_pkg::thread_id_t j_thread;
	rt_pd_pkg::scalar_t j_pixel, j_pc, j_sp;
	rt_pd_pkg::vector_t j_shader, j_normal;
	logic [31:0] lfsr;
	int errors;
	int checks;

	tb_clock_gen #(.PERIOD(10), .RESET_CYCLES(3)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	rt_pd_icm_interface #(
		.SCALAR_DEPTH(rt_pd_pkg::NUM_SCALAR_REGS),
		.VECTOR_DEPTH(rt_pd_pkg::NUM_VECTOR_REGS)
	) u_dut (.*);

	// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[126:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_scalar(input string name, input rt_pd_pkg::scalar_t exp, act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_vector(input string name, input rt_pd_pkg::vector_t exp, act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_thread(input string name, input rt_pd_pkg::thread_id_t exp, act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	// 0 kernel_mode, 1 context_switch_pd, 2 task_done_pd
	task automatic wait_flag(input int sel, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!(sel == 0 ? kernel_mode : (sel == 1 ? context_switch_pd : task_done_pd))
				&& n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			errors++;
			$display("Timed out waiting for %s to go high", what);
		end
	endtask

	task automatic check_reset_state();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			$display("Reset was never released");
		end
		@(negedge clk);
		check_flag("kernel_mode", 1'b0, kernel_mode);
		check_flag("context_switch_pd", 1'b0, context_switch_pd);
		check_flag("task_done_pd", 1'b0, task_done_pd);
	endtask

	task automatic assign_job();
		@(posedge clk);
		job_assign <= 1'b1;
		thread_id_in <= j_thread;
		pixel_id_in <= j_pixel;
		program_counter_in <= j_pc;
		stack_ptr_in <= j_sp;
		shader_info <= j_shader;
		normal <= j_normal;
		@(posedge clk);
		job_assign <= 1'b0;
	endtask

	task automatic measure_load();
		int n;
		n = 0;
		wait_flag(0, "kernel_mode");
		while (kernel_mode && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		check_scalar("kernel_mode cycles", rt_pd_pkg::scalar_t'(rt_pd_pkg::LOAD_CYCLES),
			rt_pd_pkg::scalar_t'(n));
	endtask

	task automatic read_pair(input rt_pd_pkg::sreg_addr_t sa, input rt_pd_pkg::scalar_t se,
			input rt_pd_pkg::vreg_addr_t va, input rt_pd_pkg::vector_t ve);
		@(posedge clk);
		core_scalar_rd_addr <= sa;
		core_vector_rd_addr <= va;
		@(negedge clk);
		check_scalar("core_scalar_rd_data", se, core_scalar_rd_data);
		check_vector("core_vector_rd_data", ve, core_vector_rd_data);
	endtask

	task automatic read_back_job();
		read_pair(rt_pd_pkg::SREG_PC, j_pc, rt_pd_pkg::VREG_SHADER, j_shader);
		read_pair(rt_pd_pkg::SREG_SP, j_sp, rt_pd_pkg::VREG_NORMAL, j_normal);
		read_pair(rt_pd_pkg::SREG_PIXEL_ID, j_pixel, rt_pd_pkg::VREG_SHADER, j_shader);
		// Thread id is zero extended into its scalar
		read_pair(rt_pd_pkg::SREG_THREAD_ID, rt_pd_pkg::scalar_t'(j_thread),
			rt_pd_pkg::VREG_NORMAL, j_normal);
	endtask

	task automatic reassign_while_busy();
		@(posedge clk);
		job_assign <= 1'b1;
		thread_id_in <= ~j_thread;
		pixel_id_in <= ~j_pixel;
		program_counter_in <= ~j_pc;
		stack_ptr_in <= ~j_sp;
		shader_info <= ~j_shader;
		normal <= ~j_normal;
		@(posedge clk);
		job_assign <= 1'b0;
		repeat (2 * rt_pd_pkg::LOAD_CYCLES) begin
			@(negedge clk);
			check_flag("kernel_mode", 1'b0, kernel_mode);
		end
		read_back_job();
	endtask

	task automatic core_switch(input rt_pd_pkg::scalar_t pc, input rt_pd_pkg::scalar_t sp);
		@(posedge clk);
		core_scalar_we <= 1'b1;
		core_scalar_wb_addr <= rt_pd_pkg::SREG_PC;
		core_scalar_wb_data <= pc;
		@(posedge clk);
		core_scalar_wb_addr <= rt_pd_pkg::SREG_SP;
		core_scalar_wb_data <= sp;
		@(posedge clk);
		core_scalar_we <= 1'b0;
		context_switch_rt <= 1'b1;
		@(posedge clk);
		context_switch_rt <= 1'b0;
		wait_flag(1, "context_switch_pd");
		check_scalar("program_counter_out", pc, program_counter_out);
		check_scalar("stack_ptr_out", sp, stack_ptr_out);
		check_thread("thread_id_out", j_thread, thread_id_out);
		// Single cycle pulse
		@(negedge clk);
		check_flag("context_switch_pd", 1'b0, context_switch_pd);
	endtask

	task automatic core_end(input rt_pd_pkg::scalar_t dq, input rt_pd_pkg::vector_t org,
			input rt_pd_pkg::vector_t dir);
		@(posedge clk);
		core_scalar_we <= 1'b1;
		core_scalar_wb_addr <= rt_pd_pkg::SREG_DE_Q;
		core_scalar_wb_data <= dq;
		core_vector_we <= 1'b1;
		core_vector_wb_addr <= rt_pd_pkg::VREG_ORIGIN;
		core_vector_wb_data <= org;
		@(posedge clk);
		core_scalar_we <= 1'b0;
		core_vector_wb_addr <= rt_pd_pkg::VREG_DIRECTION;
		core_vector_wb_data <= dir;
		@(posedge clk);
		core_vector_we <= 1'b0;
		end_program <= 1'b1;
		@(posedge clk);
		end_program <= 1'b0;
		wait_flag(2, "task_done_pd");
		check_flag("de_q", dq[0], de_q);
		check_vector("origin", org, origin);
		check_vector("direction", dir, direction);
		check_thread("thread_id_out", j_thread, thread_id_out);
		@(negedge clk);
		check_flag("task_done_pd", 1'b0, task_done_pd);
	endtask

	// Directed job, then an assignment that must be ignored
	task automatic run_directed_job();
		j_thread = 5'd7;
		j_pixel = 32'h0000_0123;
		j_pc = 32'h0000_0400;
		j_sp = 32'h0000_f000;
		j_shader = {4{32'h3f80_0000}};
		j_normal = {32'h0, 32'h3f80_0000, 32'h0, 32'h0};
		assign_job();
		measure_load();
		read_back_job();
		reassign_while_busy();
		core_switch(32'h0000_0480, 32'h0000_eff0);
		core_end(32'h0000_0003, {4{32'h4000_0000}}, {4{32'hbf80_0000}});
	endtask

	task automatic run_random_jobs(input int count);
		rt_pd_pkg::scalar_t pc;
		rt_pd_pkg::scalar_t sp;
		rt_pd_pkg::scalar_t dq;
		rt_pd_pkg::vector_t org;
		rt_pd_pkg::vector_t dir;
		for (int k = 0; k < count; k++) begin
			j_thread = rt_pd_pkg::thread_id_t'(rand_bits(5));
			j_pixel = rt_pd_pkg::scalar_t'(rand_bits(32));
			j_pc = rt_pd_pkg::scalar_t'(rand_bits(32));
			j_sp = rt_pd_pkg::scalar_t'(rand_bits(32));
			j_shader = rand_bits(128);
			j_normal = rand_bits(128);
			assign_job();
			measure_load();
			read_back_job();
			pc = rt_pd_pkg::scalar_t'(rand_bits(32));
			sp = rt_pd_pkg::scalar_t'(rand_bits(32));
			core_switch(pc, sp);
			dq = rt_pd_pkg::scalar_t'(rand_bits(32));
			org = rand_bits(128);
			dir = rand_bits(128);
			core_end(dq, org, dir);
		end
	endtask

	initial begin
		lfsr = 32'd84595;
		errors = 0;
		checks = 0;
		check_reset_state();
		run_directed_job();
		run_random_jobs(10);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
design/rt_pd_pkg.sv
design/rt_job_latch.sv
design/rt_context_loader.sv
design/rt_reg_bank.sv
design/rt_context_saver.sv
design/rt_pd_icm_interface.sv
verif/tb_clock_gen.sv
verif/tb_rt_pd_icm_interface.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rt_pd_icm_interface \
	-f verilog.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH PASSED" sim.log
